/* design/cache_geom_pkg.sv */
// Fixed geometry of 2 ways, 64 sets and 8 words of 32 bits per line; the field positions assume 32-bit byte addresses
`default_nettype none

package cache_geom_pkg;

    // Data word and line shape
    localparam int WORD_WIDTH     = 32;
    localparam int BYTE_NUM       = 4;                     // Byte lanes per word
    localparam int BANK_NUM       = 8;                     // One bank per word of a line
    localparam int BANK_SEL_WIDTH = 3;

    // Set organization
    localparam int WAY_NUM        = 2;
    localparam int SET_ADDR_WIDTH = 6;
    localparam int SET_NUM        = 1 << SET_ADDR_WIDTH;   // 64 sets

    // Request address layout
    localparam int ADDR_WIDTH     = 32;
    localparam int BANK_LSB       = 2;                     // Above the byte offset
    localparam int SET_LSB        = BANK_LSB + BANK_SEL_WIDTH;
    localparam int TAG_LSB        = SET_LSB + SET_ADDR_WIDTH;
    localparam int TAG_WIDTH      = ADDR_WIDTH - TAG_LSB;  // 21 bits

endpackage

`default_nettype wire

/* design/cache_if_pkg.sv */
// Request and response formats; requests are single-cycle strobes with no back-pressure and FILL carries a whole line
`default_nettype none

package cache_if_pkg;

    // Operation carried by a request
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_FILL  = 2'd2
    } cache_op_e;

    // Word i of the line lives in bank i
    typedef logic [cache_geom_pkg::BANK_NUM-1:0][cache_geom_pkg::WORD_WIDTH-1:0] cache_line_t;

    // One-hot way vector, zero means no way
    typedef logic [cache_geom_pkg::WAY_NUM-1:0] way_sel_t;

    typedef struct packed {
        logic                                    valid;
        cache_op_e                               op;
        logic [cache_geom_pkg::ADDR_WIDTH-1:0]   addr;
        logic [cache_geom_pkg::WORD_WIDTH-1:0]   wdata;    // WRITE data
        logic [cache_geom_pkg::BYTE_NUM-1:0]     byte_en;  // WRITE byte lanes
        cache_line_t                             line;     // FILL data
    } cache_req_t;

    // Returned one cycle after a READ or WRITE
    typedef struct packed {
        logic                                    valid;
        logic                                    hit;
        logic [cache_geom_pkg::WORD_WIDTH-1:0]   rdata;    // Only meaningful on a READ hit
    } cache_resp_t;

endpackage

`default_nettype wire

/* design/sram.sv */
// Single-port array with separate read and write addresses; one access per cycle, a write does not update dout
`timescale 1ns/1ps
`default_nettype none

module sram #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 6
) (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  ce,
    input  logic                  we,
    input  logic [ADDR_WIDTH-1:0] waddr,
    input  logic [ADDR_WIDTH-1:0] raddr,
    input  logic [DATA_WIDTH-1:0] din,
    input  logic [DATA_WIDTH-1:0] wmask,   // Bit-level write enables
    output logic [DATA_WIDTH-1:0] dout
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];

    // Masked write merges new bits into the stored word
    always_ff @(posedge clock) begin
        if (ce && we) begin
            mem[waddr] <= (mem[waddr] & ~wmask) | (din & wmask);
        end
    end

    // Output register holds its value when the bank is idle
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            dout <= '0;
        end else if (ce && !we) begin
            dout <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

/* design/cache_dataarray.sv */
// Two ways of eight word banks; read data appears one cycle after the enable, and way 0 wins if both ways were enabled
`timescale 1ns/1ps
`default_nettype none

module cache_dataarray (
    input  logic                                        clock,
    input  logic                                        reset_n,
    input  cache_if_pkg::way_sel_t                      ce_way,
    input  logic                                        we,
    input  logic [cache_geom_pkg::BANK_NUM-1:0]         ce_bank,
    input  logic [cache_geom_pkg::SET_ADDR_WIDTH-1:0]   set_addr,
    input  cache_if_pkg::cache_line_t                   din,
    input  logic [cache_geom_pkg::BANK_NUM*cache_geom_pkg::WORD_WIDTH-1:0] wmask,
    output cache_if_pkg::cache_line_t                   dout
);

    localparam int W = cache_geom_pkg::WORD_WIDTH;

    wire cache_if_pkg::cache_line_t dout_way [cache_geom_pkg::WAY_NUM];
    cache_if_pkg::way_sel_t ce_way_q;

    for (genvar w = 0; w < cache_geom_pkg::WAY_NUM; w++) begin : g_way
        for (genvar b = 0; b < cache_geom_pkg::BANK_NUM; b++) begin : g_bank
            sram #(
                .DATA_WIDTH(cache_geom_pkg::WORD_WIDTH),
                .ADDR_WIDTH(cache_geom_pkg::SET_ADDR_WIDTH)
            ) u_bank (
                .clock  (clock),
                .reset_n(reset_n),
                .ce     (ce_bank[b] & ce_way[w]),   // Bank and way enables combined
                .we     (we),
                .waddr  (set_addr),
                .raddr  (set_addr),
                .din    (din[b]),
                .wmask  (wmask[b*W +: W]),
                .dout   (dout_way[w][b])
            );
        end
    end

    // Way of the access, aligned with the bank output registers
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            ce_way_q <= '0;
        end else begin
            ce_way_q <= ce_way;
        end
    end

    // Whole-line select is the same choice made bank by bank
    assign dout = ce_way_q[0] ? dout_way[0] : dout_way[1];

endmodule

`default_nettype wire

/* design/cache_tagarray.sv */
// Flop-based tags with valid and LRU bits; a FILL drops any other copy of its tag so hit_way stays one-hot
`timescale 1ns/1ps
`default_nettype none

module cache_tagarray (
    input  logic                     clock,
    input  logic                     reset_n,
    input  cache_if_pkg::cache_req_t req,
    output cache_if_pkg::way_sel_t   hit_way,
    output cache_if_pkg::way_sel_t   victim_way
);

    logic [cache_geom_pkg::TAG_WIDTH-1:0]
        tag_mem [cache_geom_pkg::SET_NUM][cache_geom_pkg::WAY_NUM];
    logic [cache_geom_pkg::SET_NUM-1:0][cache_geom_pkg::WAY_NUM-1:0] valid_q;
    logic [cache_geom_pkg::SET_NUM-1:0] lru_q;    // Index of the way to replace next

    logic [cache_geom_pkg::SET_ADDR_WIDTH-1:0] set_idx;
    logic [cache_geom_pkg::TAG_WIDTH-1:0]      req_tag;
    logic                                      is_fill;
    logic                                      is_access;

    assign set_idx = req.addr[cache_geom_pkg::SET_LSB +: cache_geom_pkg::SET_ADDR_WIDTH];
    assign req_tag = req.addr[cache_geom_pkg::TAG_LSB +: cache_geom_pkg::TAG_WIDTH];

    assign is_fill   = req.valid && (req.op == cache_if_pkg::OP_FILL);
    assign is_access = req.valid &&
                       (req.op == cache_if_pkg::OP_READ || req.op == cache_if_pkg::OP_WRITE);

    // Combinational compare against both ways of the set
    always_comb begin
        for (int w = 0; w < cache_geom_pkg::WAY_NUM; w++) begin
            hit_way[w]    = valid_q[set_idx][w] && (tag_mem[set_idx][w] == req_tag);
            victim_way[w] = (lru_q[set_idx] == w);
        end
    end

    // Tag payload, written only on FILL
    always_ff @(posedge clock) begin
        if (is_fill) begin
            for (int w = 0; w < cache_geom_pkg::WAY_NUM; w++) begin
                if (victim_way[w]) begin
                    tag_mem[set_idx][w] <= req_tag;
                end
            end
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            valid_q <= '0;
            lru_q   <= '0;                                      // Way 0 goes first
        end else if (is_fill) begin
            valid_q[set_idx] <= (valid_q[set_idx] & ~hit_way) | victim_way;
            lru_q[set_idx]   <= ~lru_q[set_idx];                // Filled way becomes MRU
        end else if (is_access && (|hit_way)) begin
            lru_q[set_idx]   <= hit_way[0];                     // Point at the other way
        end
    end

endmodule

`default_nettype wire

/* design/dcache_ctrl.sv */
// Request decode and response path; a response follows every READ or WRITE by one cycle, FILL gets none
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic                                        clock,
    input  logic                                        reset_n,
    input  cache_if_pkg::cache_req_t                    req,
    input  cache_if_pkg::way_sel_t                      hit_way,
    input  cache_if_pkg::way_sel_t                      victim_way,
    output cache_if_pkg::way_sel_t                      ce_way,
    output logic [cache_geom_pkg::BANK_NUM-1:0]         ce_bank,
    output logic                                        we,
    output logic [cache_geom_pkg::SET_ADDR_WIDTH-1:0]   set_addr,
    output cache_if_pkg::cache_line_t                   din,
    output logic [cache_geom_pkg::BANK_NUM*cache_geom_pkg::WORD_WIDTH-1:0] wmask,
    input  cache_if_pkg::cache_line_t                   dout,
    output cache_if_pkg::cache_resp_t                   resp
);

    localparam int W  = cache_geom_pkg::WORD_WIDTH;
    localparam int BW = cache_geom_pkg::WORD_WIDTH / cache_geom_pkg::BYTE_NUM;

    logic [cache_geom_pkg::BANK_SEL_WIDTH-1:0] bank_sel;
    logic [cache_geom_pkg::BANK_SEL_WIDTH-1:0] bank_q;
    logic [cache_geom_pkg::BANK_NUM-1:0]       bank_onehot;
    logic [W-1:0]                              byte_mask;
    logic                                      is_access;
    logic                                      resp_valid_q;
    logic                                      resp_hit_q;

    assign bank_sel  = req.addr[cache_geom_pkg::BANK_LSB +: cache_geom_pkg::BANK_SEL_WIDTH];
    assign set_addr  = req.addr[cache_geom_pkg::SET_LSB +: cache_geom_pkg::SET_ADDR_WIDTH];
    assign is_access = req.valid &&
                       (req.op == cache_if_pkg::OP_READ || req.op == cache_if_pkg::OP_WRITE);

    always_comb begin
        for (int b = 0; b < cache_geom_pkg::BANK_NUM; b++) begin
            bank_onehot[b] = (bank_sel == b);
        end
        for (int i = 0; i < cache_geom_pkg::BYTE_NUM; i++) begin
            byte_mask[i*BW +: BW] = {BW{req.byte_en[i]}};   // Byte enable to bit lanes
        end
    end

    // Data-array controls per opcode
    always_comb begin
        ce_way  = '0;
        ce_bank = '0;
        we      = 1'b0;
        din     = req.line;
        wmask   = '0;
        if (req.valid) begin
            case (req.op)
                cache_if_pkg::OP_READ: begin
                    ce_way  = hit_way;                      // Miss enables no way
                    ce_bank = bank_onehot;
                end
                cache_if_pkg::OP_WRITE: begin
                    ce_way  = hit_way;
                    ce_bank = bank_onehot;
                    we      = 1'b1;
                    din     = {cache_geom_pkg::BANK_NUM{req.wdata}};
                    wmask[bank_sel*W +: W] = byte_mask;
                end
                cache_if_pkg::OP_FILL: begin
                    ce_way  = victim_way;
                    ce_bank = '1;                           // Whole line
                    we      = 1'b1;
                    wmask   = '1;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            resp_valid_q <= 1'b0;
            resp_hit_q   <= 1'b0;
        end else begin
            resp_valid_q <= is_access;
            resp_hit_q   <= is_access && (|hit_way);
        end
    end

    // Word select follows the bank of the request
    always_ff @(posedge clock) begin
        bank_q <= bank_sel;
    end

    always_comb begin
        resp.valid = resp_valid_q;
        resp.hit   = resp_hit_q;
        resp.rdata = dout[bank_q];
    end

endmodule

`default_nettype wire

/* design/dcache_top.sv */
// Data path of a two-way data cache; no miss handling, write-back or stalls, and FILL data comes from the requester
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                     clock,
    input  logic                     reset_n,
    input  cache_if_pkg::cache_req_t req,
    output cache_if_pkg::cache_resp_t resp
);

    cache_if_pkg::way_sel_t                                         hit_way;
    cache_if_pkg::way_sel_t                                         victim_way;
    cache_if_pkg::way_sel_t                                         ce_way;
    logic [cache_geom_pkg::BANK_NUM-1:0]                            ce_bank;
    logic                                                           we;
    logic [cache_geom_pkg::SET_ADDR_WIDTH-1:0]                      set_addr;
    cache_if_pkg::cache_line_t                                      din;
    logic [cache_geom_pkg::BANK_NUM*cache_geom_pkg::WORD_WIDTH-1:0] wmask;
    cache_if_pkg::cache_line_t                                      dout;

    dcache_ctrl u_ctrl (
        .clock     (clock),
        .reset_n   (reset_n),
        .req       (req),
        .hit_way   (hit_way),
        .victim_way(victim_way),
        .ce_way    (ce_way),
        .ce_bank   (ce_bank),
        .we        (we),
        .set_addr  (set_addr),
        .din       (din),
        .wmask     (wmask),
        .dout      (dout),
        .resp      (resp)
    );

    cache_tagarray u_tagarray (
        .clock     (clock),
        .reset_n   (reset_n),
        .req       (req),
        .hit_way   (hit_way),
        .victim_way(victim_way)
    );

    cache_dataarray u_dataarray (
        .clock   (clock),
        .reset_n (reset_n),
        .ce_way  (ce_way),
        .we      (we),
        .ce_bank (ce_bank),
        .set_addr(set_addr),
        .din     (din),
        .wmask   (wmask),
        .dout    (dout)
    );

endmodule

`default_nettype wire

/* tb/dcache_assertions.sv */
// Bound to dcache_top; assumes single-cycle requests with no back-pressure, error_count is read by the testbench
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input logic                                clock,
    input logic                                reset_n,
    input cache_if_pkg::cache_req_t            req,
    input cache_if_pkg::cache_resp_t           resp,
    input cache_if_pkg::way_sel_t              ce_way,
    input logic                                we,
    input logic [cache_geom_pkg::BANK_NUM-1:0] ce_bank
);

    int   error_count = 0;
    logic is_access;

    assign is_access = req.valid &&
                       (req.op == cache_if_pkg::OP_READ || req.op == cache_if_pkg::OP_WRITE);

    a_quiet_in_reset: assert property (@(posedge clock) !reset_n |-> !resp.valid)
        else begin
            $error("resp.valid high during reset");
            error_count++;
        end

    // One response per READ or WRITE, exactly one cycle later
    a_resp_follows: assert property (@(posedge clock) disable iff (!reset_n)
        is_access |=> resp.valid)
        else begin
            $error("No response one cycle after a READ or WRITE");
            error_count++;
        end

    // Idle cycles and FILLs produce nothing
    a_no_stray_resp: assert property (@(posedge clock) disable iff (!reset_n)
        !is_access |=> !resp.valid)
        else begin
            $error("Response without a READ or WRITE");
            error_count++;
        end

    a_way_onehot: assert property (@(posedge clock) disable iff (!reset_n) $onehot0(ce_way))
        else begin
            $error("More than one way enabled");
            error_count++;
        end

    a_write_has_bank: assert property (@(posedge clock) disable iff (!reset_n)
        we |-> (ce_bank != '0))
        else begin
            $error("Write with no bank enabled");
            error_count++;
        end

endmodule

bind dcache_top dcache_assertions u_assertions (.*);

`default_nettype wire

/* tb/tb_dcache.sv */
// Directed and seeded random traffic against a reference model; only 3 tags and 4 sets are used
`timescale 1ns/1ps
`default_nettype none

module tb_dcache;

    localparam int NSET          = cache_geom_pkg::SET_NUM;
    localparam int NWAY          = cache_geom_pkg::WAY_NUM;
    localparam int RANDOM_CYCLES = 3000;

    logic                      clock;
    logic                      reset_n;
    cache_if_pkg::cache_req_t  req;
    cache_if_pkg::cache_resp_t resp;

    int seed = 32'h98ce_b3eb;
    logic [cache_geom_pkg::TAG_WIDTH-1:0] tag_pool [3];
    int                                   set_pool [4];

    // Reference model of tags, valid bits, LRU and line data
    logic [cache_geom_pkg::TAG_WIDTH-1:0] m_tag   [NSET][NWAY];
    bit                                   m_valid [NSET][NWAY];
    int                                   m_lru   [NSET];        // Way replaced next
    cache_if_pkg::cache_line_t            m_data  [NSET][NWAY];

    logic        exp_valid;
    logic        exp_hit;
    logic        exp_has_data;                                  // READ hit, rdata is checked
    logic [31:0] exp_rdata;

    dcache_top DUT (.clock(clock), .reset_n(reset_n), .req(req), .resp(resp));

    always #4 clock = ~clock;

    function automatic logic [31:0] make_addr(input logic [20:0] tag, input int set,
                                              input int bank);
        logic [31:0] a;
        a = '0;
        a[cache_geom_pkg::TAG_LSB +: cache_geom_pkg::TAG_WIDTH]       = tag;
        a[cache_geom_pkg::SET_LSB +: cache_geom_pkg::SET_ADDR_WIDTH]  = set[5:0];
        a[cache_geom_pkg::BANK_LSB +: cache_geom_pkg::BANK_SEL_WIDTH] = bank[2:0];
        return a;
    endfunction

    function automatic cache_if_pkg::cache_line_t rand_line();
        cache_if_pkg::cache_line_t l;
        for (int i = 0; i < cache_geom_pkg::BANK_NUM; i++) begin
            l[i] = $random(seed);
        end
        return l;
    endfunction

    function automatic int lookup(input int s, input logic [20:0] t);
        for (int w = 0; w < NWAY; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) return w;
        end
        return -1;                                              // Miss
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
        $display("TB FAILED");
        $fatal(1, "Response mismatch");
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout: %s", what);
        $display("TB FAILED");
        $fatal(1, "Wait timed out");
    endtask

    task automatic protocol_fail();
        $display("A concurrent assertion on the DUT failed at %0t", $time);
        $display("TB FAILED");
        $fatal(1, "Assertion failure");
    endtask

    task automatic check_response();
        assert (DUT.u_assertions.error_count == 0)
            else protocol_fail();
        assert (resp.valid === exp_valid)
            else report_mismatch("resp.valid", 32'(exp_valid), 32'(resp.valid));
        assert (resp.hit === exp_hit)
            else report_mismatch("resp.hit", 32'(exp_hit), 32'(resp.hit));
        if (exp_has_data) begin
            assert (resp.rdata === exp_rdata)
                else report_mismatch("resp.rdata", exp_rdata, resp.rdata);
        end
    endtask

    // One request per falling edge; the previous request's response is checked first
    task automatic issue(input logic valid, input cache_if_pkg::cache_op_e op,
                         input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] byte_en, input cache_if_pkg::cache_line_t line);
        int          s;
        int          b;
        int          hw;
        int          vw;
        logic [20:0] t;
        logic [31:0] word;
        @(negedge clock);
        check_response();
        req.valid   = valid;
        req.op      = op;
        req.addr    = addr;
        req.wdata   = wdata;
        req.byte_en = byte_en;
        req.line    = line;
        s  = addr[cache_geom_pkg::SET_LSB +: cache_geom_pkg::SET_ADDR_WIDTH];
        b  = addr[cache_geom_pkg::BANK_LSB +: cache_geom_pkg::BANK_SEL_WIDTH];
        t  = addr[cache_geom_pkg::TAG_LSB +: cache_geom_pkg::TAG_WIDTH];
        hw = lookup(s, t);
        exp_valid    = valid && (op == cache_if_pkg::OP_READ || op == cache_if_pkg::OP_WRITE);
        exp_hit      = exp_valid && (hw >= 0);
        exp_has_data = exp_hit && (op == cache_if_pkg::OP_READ);
        if (exp_has_data) exp_rdata = m_data[s][hw][b];
        if (exp_hit) begin
            m_lru[s] = (hw == 0) ? 1 : 0;                       // Other way becomes LRU
            if (op == cache_if_pkg::OP_WRITE) begin
                word = m_data[s][hw][b];
                for (int i = 0; i < 4; i++) begin
                    if (byte_en[i]) word[i*8 +: 8] = wdata[i*8 +: 8];
                end
                m_data[s][hw][b] = word;
            end
        end else if (valid && op == cache_if_pkg::OP_FILL) begin
            vw = m_lru[s];
            if (hw >= 0 && hw != vw) m_valid[s][hw] = 1'b0;     // Older copy of the same tag
            m_tag[s][vw]   = t;
            m_valid[s][vw] = 1'b1;
            m_data[s][vw]  = line;
            m_lru[s]       = 1 - vw;
        end
    endtask

    initial begin
        int          cycles;
        int          r;
        logic [31:0] a;
        clock        = 1'b0;
        reset_n      = 1'b0;
        req          = '0;
        exp_valid    = 1'b0;
        exp_hit      = 1'b0;
        exp_has_data = 1'b0;
        exp_rdata    = '0;
        tag_pool     = '{21'h0_00a5, 21'h1_2345, 21'h1f_ffff};
        set_pool     = '{0, 1, 17, 63};
        for (int s = 0; s < NSET; s++) begin
            m_lru[s] = 0;
            for (int w = 0; w < NWAY; w++) m_valid[s][w] = 1'b0;
        end
        repeat (10) @(negedge clock);
        reset_n = 1'b1;
        cycles  = 0;
        while (resp.valid !== 1'b0) begin
            if (cycles == 20) timeout_fail("resp.valid still high after reset");
            @(negedge clock);
            cycles++;
        end

        // Cold cache misses, then fill a line and read all of it back
        issue(1'b1, cache_if_pkg::OP_READ, make_addr(tag_pool[0], 0, 0), '0, '0, '0);
        issue(1'b1, cache_if_pkg::OP_WRITE, make_addr(tag_pool[1], 1, 5), $random(seed), 4'hf, '0);
        issue(1'b1, cache_if_pkg::OP_FILL, make_addr(tag_pool[0], 0, 0), '0, '0, rand_line());
        for (int b = 0; b < 8; b++) begin
            issue(1'b1, cache_if_pkg::OP_READ, make_addr(tag_pool[0], 0, b), '0, '0, '0);
        end
        // Partial write hit merges bytes
        issue(1'b1, cache_if_pkg::OP_WRITE, make_addr(tag_pool[0], 0, 3), $random(seed), 4'b0101, '0);
        issue(1'b1, cache_if_pkg::OP_READ, make_addr(tag_pool[0], 0, 3), '0, '0, '0);
        // Write miss leaves nothing behind
        issue(1'b1, cache_if_pkg::OP_WRITE, make_addr(tag_pool[2], 0, 3), $random(seed), 4'hf, '0);
        issue(1'b1, cache_if_pkg::OP_READ, make_addr(tag_pool[0], 0, 3), '0, '0, '0);
        issue(1'b1, cache_if_pkg::OP_WRITE, make_addr(tag_pool[1], 1, 2), $random(seed), 4'hf, '0);
        issue(1'b1, cache_if_pkg::OP_FILL, make_addr(tag_pool[1], 1, 0), '0, '0, rand_line());
        issue(1'b1, cache_if_pkg::OP_READ, make_addr(tag_pool[1], 1, 2), '0, '0, '0);
        // LRU: touch tag 0, so the third fill evicts tag 1
        issue(1'b1, cache_if_pkg::OP_FILL, make_addr(tag_pool[0], 17, 0), '0, '0, rand_line());
        issue(1'b1, cache_if_pkg::OP_FILL, make_addr(tag_pool[1], 17, 0), '0, '0, rand_line());
        issue(1'b1, cache_if_pkg::OP_READ, make_addr(tag_pool[0], 17, 1), '0, '0, '0);
        issue(1'b1, cache_if_pkg::OP_FILL, make_addr(tag_pool[2], 17, 0), '0, '0, rand_line());
        for (int i = 0; i < 3; i++) begin
            issue(1'b1, cache_if_pkg::OP_READ, make_addr(tag_pool[i], 17, 6), '0, '0, '0);
        end

        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            r = $unsigned($random(seed)) % 4;
            a = make_addr(tag_pool[$unsigned($random(seed)) % 3],
                          set_pool[$unsigned($random(seed)) % 4], $unsigned($random(seed)) % 8);
            case (r)
                0:       issue(1'b0, cache_if_pkg::OP_READ, a, '0, '0, '0);
                1:       issue(1'b1, cache_if_pkg::OP_READ, a, '0, '0, '0);
                2:       issue(1'b1, cache_if_pkg::OP_WRITE, a, $random(seed),
                               4'($random(seed)), '0);
                default: issue(1'b1, cache_if_pkg::OP_FILL, a, '0, '0, rand_line());
            endcase
        end

        // Drain the last response
        cycles = 0;
        do begin
            if (cycles == 8) timeout_fail("response path did not go idle");
            issue(1'b0, cache_if_pkg::OP_READ, '0, '0, '0, '0);
            cycles++;
        end while (resp.valid !== 1'b0);

        if (DUT.u_assertions.error_count != 0) begin
            $display("%0d concurrent assertion failures", DUT.u_assertions.error_count);
            $display("TB FAILED");
            $fatal(1, "Assertion failures");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
design/cache_geom_pkg.sv
design/cache_if_pkg.sv
design/sram.sv
design/cache_dataarray.sv
design/cache_tagarray.sv
design/dcache_ctrl.sv
design/dcache_top.sv
tb/dcache_assertions.sv
tb/tb_dcache.sv
